//--- keypad_pkg.sv
package keypad_pkg;

    typedef logic [3:0]  lines_t;      // One bit per row or column line, active low.
    typedef logic [3:0]  key_code_t;   // Row * 4 + column.
    typedef logic [2:0]  fifo_count_t;
    typedef logic [20:0] debounce_t;   // Holds 20 ms at 100 MHz.
    typedef logic [1:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    typedef enum logic [2:0] {
        IDLE,
        SCAN_FIRST,
        DEBOUNCE,
        SCAN_SECOND,
        CHECK,
        WAIT_RELEASE
    } scan_state_t;

    // Event FIFO geometry.
    localparam fifo_count_t FIFO_DEPTH = 3'd4;
    localparam int          FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Row synchronizer delay seen by the scanner after each column change.
    localparam logic [1:0] SETTLE_CYCLES = 2'd2;

    localparam lines_t ALL_LINES_HIGH = 4'b1111;
    localparam lines_t ALL_LINES_LOW  = 4'b0000;

    // Register map, word addresses.
    localparam wb_addr_t REG_STATUS   = 2'd0;
    localparam wb_addr_t REG_DATA     = 2'd1;
    localparam wb_addr_t REG_DEBOUNCE = 2'd2;
    localparam wb_addr_t REG_CTRL     = 2'd3;

    // Bit positions inside the registers.
    localparam int STATUS_EMPTY_BIT = 3;
    localparam int STATUS_OVF_BIT   = 4;
    localparam int DATA_VALID_BIT   = 8;
    localparam int CTRL_ENABLE_BIT  = 0;
    localparam int CTRL_CLR_OVF_BIT = 1;

    // Reset values.
    localparam debounce_t DEBOUNCE_RESET    = 21'd2_000_000;
    localparam logic      SCAN_ENABLE_RESET = 1'b1;

endpackage

//--- keypad_scanner.sv
`timescale 1ns/1ps

module keypad_scanner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::lines_t    row_in,
    input  logic                  scan_enable,
    input  keypad_pkg::debounce_t debounce_len,
    output keypad_pkg::lines_t    col_out,
    output keypad_pkg::key_event_t key_event
);

    import keypad_pkg::*;

    scan_state_t state;
    lines_t      row_meta;
    lines_t      row_sync;
    logic [1:0]  col_idx;
    logic [1:0]  settle_cnt;
    debounce_t   wait_cnt;
    key_code_t   first_code;
    key_code_t   second_code;
    logic        rows_idle;

    // Drive exactly one column low.
    function automatic lines_t col_drive(input logic [1:0] idx);
        lines_t one_hot;
        one_hot = lines_t'(4'b0001 << idx);
        return ~one_hot;
    endfunction

    function automatic logic single_low(input lines_t rows);
        return $countones(~rows) == 1;
    endfunction

    // Index of the low row, only meaningful when exactly one row is low.
    function automatic logic [1:0] low_row(input lines_t rows);
        logic [1:0] idx;
        idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!rows[r]) begin
                idx = 2'(r);
            end
        end
        return idx;
    endfunction

    assign rows_idle = (row_sync == ALL_LINES_HIGH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_meta        <= ALL_LINES_HIGH;
            row_sync        <= ALL_LINES_HIGH;
            state           <= IDLE;
            col_out         <= ALL_LINES_HIGH;
            key_event.valid <= 1'b0;
        end else begin
            row_meta        <= row_in;
            row_sync        <= row_meta;
            key_event.valid <= 1'b0;

            if (!scan_enable) begin
                state   <= IDLE;             // Scanning off, release all columns.
                col_out <= ALL_LINES_HIGH;
            end else begin
                case (state)
                    IDLE: begin
                        if (!rows_idle && col_out == ALL_LINES_LOW) begin
                            state      <= SCAN_FIRST;
                            col_idx    <= 2'd0;
                            col_out    <= col_drive(2'd0);
                            settle_cnt <= '0;
                        end else begin
                            col_out    <= ALL_LINES_LOW;
                        end
                    end

                    // Both scans step through the columns the same way.
                    SCAN_FIRST, SCAN_SECOND: begin
                        if (settle_cnt != SETTLE_CYCLES) begin
                            settle_cnt <= settle_cnt + 2'd1;
                        end else if (rows_idle) begin
                            if (col_idx == 2'd3) begin
                                state   <= IDLE;     // No key found in any column.
                                col_out <= ALL_LINES_LOW;
                            end else begin
                                col_idx    <= col_idx + 2'd1;
                                col_out    <= col_drive(col_idx + 2'd1);
                                settle_cnt <= '0;
                            end
                        end else if (single_low(row_sync)) begin
                            if (state == SCAN_FIRST) begin
                                first_code <= {low_row(row_sync), col_idx};
                                state      <= DEBOUNCE;
                                col_out    <= ALL_LINES_LOW;
                                wait_cnt   <= '0;
                            end else begin
                                second_code <= {low_row(row_sync), col_idx};
                                state       <= CHECK;
                            end
                        end else begin
                            state   <= IDLE;         // Several rows low in one column.
                            col_out <= ALL_LINES_LOW;
                        end
                    end

                    DEBOUNCE: begin
                        if (rows_idle) begin
                            state <= IDLE;           // Key let go too early.
                        end else if (wait_cnt == debounce_len) begin
                            state      <= SCAN_SECOND;
                            col_idx    <= 2'd0;
                            col_out    <= col_drive(2'd0);
                            settle_cnt <= '0;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end

                    CHECK: begin
                        if (first_code == second_code) begin
                            key_event.valid <= 1'b1;
                            key_event.code  <= first_code;
                        end
                        state    <= WAIT_RELEASE;
                        col_out  <= ALL_LINES_LOW;
                        wait_cnt <= '0;
                    end

                    // All rows must stay high for a full debounce time.
                    WAIT_RELEASE: begin
                        if (!rows_idle) begin
                            wait_cnt <= '0;
                        end else if (wait_cnt == debounce_len) begin
                            state <= IDLE;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end

                    default: begin
                        state   <= IDLE;
                        col_out <= ALL_LINES_LOW;
                    end
                endcase
            end
        end
    end

endmodule

//--- key_event_fifo.sv
`timescale 1ns/1ps

module key_event_fifo (
    input  logic                    clk,
    input  logic                    rst_n,
    input  keypad_pkg::key_event_t  key_event,
    input  logic                    pop,
    input  logic                    clear_overflow,
    output keypad_pkg::key_code_t   head,
    output keypad_pkg::fifo_count_t count,
    output logic                    overflow
);

    import keypad_pkg::*;

    key_code_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == FIFO_DEPTH);
    assign do_push = key_event.valid && !full;
    assign do_pop  = pop && (count != '0);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= key_event.code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fifo_count_t'(do_push) - fifo_count_t'(do_pop);

            // A new drop wins over a clear in the same cycle.
            if (key_event.valid && full) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

//--- keypad_wb_regs.sv
`timescale 1ns/1ps

module keypad_wb_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  keypad_pkg::wb_addr_t    wb_adr,
    input  keypad_pkg::wb_data_t    wb_dat_w,
    input  keypad_pkg::key_code_t   head,
    input  keypad_pkg::fifo_count_t count,
    input  logic                    overflow,
    output keypad_pkg::wb_data_t    wb_dat_r,
    output logic                    wb_ack,
    output logic                    pop,
    output logic                    clear_overflow,
    output logic                    scan_enable,
    output keypad_pkg::debounce_t   debounce_len
);

    import keypad_pkg::*;

    logic request;
    logic write_cycle;
    logic read_cycle;

    // Ack is held off for one cycle after each ack so every access gets one pulse.
    assign request     = wb_cyc && wb_stb && !wb_ack;
    assign write_cycle = wb_ack && wb_we;
    assign read_cycle  = wb_ack && !wb_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debounce_len <= DEBOUNCE_RESET;
            scan_enable  <= SCAN_ENABLE_RESET;
        end else if (write_cycle) begin
            case (wb_adr)
                REG_DEBOUNCE: debounce_len <= wb_dat_w[$bits(debounce_t)-1:0];
                REG_CTRL:     scan_enable  <= wb_dat_w[CTRL_ENABLE_BIT];
                default:      ;              // Status and data are read only.
            endcase
        end
    end

    assign pop            = read_cycle && (wb_adr == REG_DATA);
    assign clear_overflow = write_cycle && (wb_adr == REG_CTRL) && wb_dat_w[CTRL_CLR_OVF_BIT];

    // Read data follows the live FIFO state, so it matches the pop in the ack cycle.
    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            REG_STATUS: begin
                wb_dat_r[$bits(fifo_count_t)-1:0] = count;
                wb_dat_r[STATUS_EMPTY_BIT]         = (count == '0);
                wb_dat_r[STATUS_OVF_BIT]           = overflow;
            end
            REG_DATA: begin
                wb_dat_r[$bits(key_code_t)-1:0] = head;
                wb_dat_r[DATA_VALID_BIT]         = (count != '0);
            end
            REG_DEBOUNCE: begin
                wb_dat_r = wb_data_t'(debounce_len);
            end
            REG_CTRL: begin
                wb_dat_r[CTRL_ENABLE_BIT] = scan_enable;
            end
            default: begin
                wb_dat_r = '0;
            end
        endcase
    end

endmodule

//--- keypad_top.sv
`timescale 1ns/1ps

module keypad_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  keypad_pkg::lines_t   row_in,
    output keypad_pkg::lines_t   col_out,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  keypad_pkg::wb_addr_t wb_adr,
    input  keypad_pkg::wb_data_t wb_dat_w,
    output keypad_pkg::wb_data_t wb_dat_r,
    output logic                 wb_ack
);

    import keypad_pkg::*;

    key_event_t  key_event;
    key_code_t   head;
    fifo_count_t count;
    logic        overflow;
    logic        pop;
    logic        clear_overflow;
    logic        scan_enable;
    debounce_t   debounce_len;

    keypad_scanner u_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_in       (row_in),
        .scan_enable  (scan_enable),
        .debounce_len (debounce_len),
        .col_out      (col_out),
        .key_event    (key_event)
    );

    key_event_fifo u_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_event      (key_event),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head           (head),
        .count          (count),
        .overflow       (overflow)
    );

    keypad_wb_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .head           (head),
        .count          (count),
        .overflow       (overflow),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .scan_enable    (scan_enable),
        .debounce_len   (debounce_len)
    );

endmodule

//--- tb_keypad.sv
`timescale 1ns/1ps

module tb_keypad;

    import keypad_pkg::*;

    localparam int CYCLE_LIMIT = 20000; // The cases take under 5000 cycles.

    logic     clk;
    logic     rst_n;
    lines_t   row_in;
    lines_t   col_out;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    logic      key_down;
    key_code_t key_code;
    key_code_t rand_code;
    integer    seed;
    integer    errors;
    integer    cycles;

    keypad_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .row_in   (row_in),
        .col_out  (col_out),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // The pressed key pulls its row low while its column is driven low.
    always_comb begin
        row_in = ALL_LINES_HIGH;
        if (key_down && !col_out[key_code[1:0]]) begin
            row_in[key_code[3:2]] = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t data,
                             output wb_data_t rdata);
        int waited;
        @(posedge clk);
        assert (!wb_ack) else begin
            $display("Wishbone ack was still high when a new access started");
            errors++;
        end
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= data;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack);
        // Ack is high in the cycle after the request and is sampled at the edge that ends it.
        assert (waited == 2) else begin
            $display("Wishbone ack came %0d cycles after the request instead of 2", waited);
            errors++;
        end
        rdata = wb_dat_r;         // Read data is valid in the ack cycle.
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_value(input string name, input wb_data_t expected,
                               input wb_data_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic hold_key(input key_code_t code, input int hold);
        @(posedge clk);
        key_code <= code;
        key_down <= 1'b1;
        repeat (hold) @(posedge clk);
    endtask

    // Polls the status register until the FIFO count matches.
    task automatic wait_count(input string name, input int target, input int bound);
        int       start;
        wb_data_t status;
        start = cycles;
        wb_access(1'b0, REG_STATUS, '0, status);
        while (int'(status[2:0]) != target && cycles - start < bound) begin
            wb_access(1'b0, REG_STATUS, '0, status);
        end
        assert (int'(status[2:0]) == target) else begin
            $display("%s: the event count did not reach %0d within %0d cycles",
                     name, target, bound);
            errors++;
        end
    endtask

    task automatic run_case(input string name, input string op, input int a, input int b);
        wb_data_t data;
        if (op == "write") begin
            wb_access(1'b1, wb_addr_t'(a), wb_data_t'(b), data);
        end else if (op == "read") begin
            wb_access(1'b0, wb_addr_t'(a), '0, data);
            check_value(name, wb_data_t'(b), data);
        end else if (op == "press") begin
            hold_key(key_code_t'(a), b);
        end else if (op == "rpress") begin
            rand_code = key_code_t'($random(seed));
            hold_key(rand_code, b);
        end else if (op == "rread") begin
            wb_access(1'b0, REG_DATA, '0, data);
            check_value(name, (32'd1 << DATA_VALID_BIT) | wb_data_t'(rand_code), data);
        end else if (op == "nodata") begin
            wb_access(1'b0, REG_DATA, '0, data);
            check_value(name, 32'd0, wb_data_t'(data[DATA_VALID_BIT]));
        end else if (op == "release") begin
            @(posedge clk);
            key_down <= 1'b0;
            repeat (b) @(posedge clk);
        end else if (op == "idle") begin
            repeat (b) @(posedge clk);
        end else if (op == "wait") begin
            wait_count(name, a, b);
        end else if (op == "cols") begin
            @(posedge clk);
            check_value(name, wb_data_t'(a), wb_data_t'(col_out));
        end else begin
            $display("%s: unknown operation %s in the cases file", name, op);
            errors++;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        string line;
        string name;
        string op;
        seed      = 52;
        errors    = 0;
        cycles    = 0;
        key_down  = 1'b0;
        key_code  = '0;
        rand_code = '0;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("keypad_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open keypad_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines do not give four fields.
                if (n > 0 && $sscanf(line, "%s %s %d %d", name, op, a, b) == 4) begin
                    run_case(name, op, a, b);
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- keypad_cases.txt
# Columns: name operation a b, numbers in decimal.
# write adr data, read adr expect, press code cycles, release 0 idle, idle 0 cycles
# wait count bound, rpress 0 cycles, rread 0 0, nodata 0 0, cols expect 0
rst_status read 0 8
rst_debounce read 2 2000000
rst_ctrl read 3 1
setup write 2 8
setup_check read 2 8
rand1_press rpress 0 60
rand1_release release 0 20
rand1_wait wait 1 200
rand1_read rread 0 0
rand1_empty nodata 0 0
rand2_press rpress 0 60
rand2_release release 0 20
rand2_wait wait 1 200
rand2_read rread 0 0
rand2_empty nodata 0 0
short_press press 5 3
short_release release 0 100
short_status read 0 8
long_press press 9 400
long_release release 0 20
long_status read 0 1
long_read read 1 265
ovf_press1 press 1 60
ovf_release1 release 0 20
ovf_press2 press 6 60
ovf_release2 release 0 20
ovf_press3 press 11 60
ovf_release3 release 0 20
ovf_press4 press 12 60
ovf_release4 release 0 20
ovf_press5 press 15 60
ovf_release5 release 0 20
ovf_status read 0 20
ovf_read1 read 1 257
ovf_read2 read 1 262
ovf_read3 read 1 267
ovf_read4 read 1 268
ovf_clear write 3 3
ovf_cleared read 0 8
ovf_ctrl read 3 1
dis_write write 3 0
dis_press press 7 60
dis_cols cols 15 0
dis_release release 0 20
dis_status read 0 8
en_write write 3 1
en_press press 14 60
en_release release 0 20
en_wait wait 1 200
en_read read 1 270
end_status read 0 8

//--- project.f
keypad_pkg.sv
keypad_scanner.sv
key_event_fifo.sv
keypad_wb_regs.sv
keypad_top.sv
tb_keypad.sv

//--- run.sh
#!/bin/sh
# Builds the keypad testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_keypad \
    -Mdir obj_dir -o sim_keypad
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_keypad > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
fi
exit 1
